/* all.f */
sizingPkg.sv
uopPkg.sv
reservationStation.sv
intLane.sv
writebackStage.sv
issueCore.sv
issueCore_props.sv
tbIssueCore.sv

/* intLane.sv */
`timescale 1ns/100ps

module intLane (
    input  logic               clk,
    input  logic               rst,
    input  logic               issueValid,
    input  uopPkg::laneIssue_t issue,
    output uopPkg::resultBus_t laneResult
);
    import sizingPkg::*;
    import uopPkg::*;

    data_t aluOut;
    logic  ltSigned;
    logic  ltUnsigned;

    assign ltSigned   = $signed(issue.valueA) < $signed(issue.valueB);
    assign ltUnsigned = issue.valueA < issue.valueB;

    always_comb begin
        case (issue.op)
            INT_ADD: begin
                aluOut = issue.valueA + issue.valueB;
            end
            INT_SUB: begin
                aluOut = issue.valueA - issue.valueB;
            end
            INT_AND: begin
                aluOut = issue.valueA & issue.valueB;
            end
            INT_OR: begin
                aluOut = issue.valueA | issue.valueB;
            end
            INT_XOR: begin
                aluOut = issue.valueA ^ issue.valueB;
            end
            INT_SLT: begin
                aluOut = {{(DATA_W-1){1'b0}}, ltSigned};
            end
            INT_SLTU: begin
                aluOut = {{(DATA_W-1){1'b0}}, ltUnsigned};
            end
            INT_CSRR: begin
                // csr value arrives as operand A.
                aluOut = issue.valueA;
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        laneResult.sqN   <= issue.sqN;
        laneResult.tag   <= issue.tagDst;
        laneResult.value <= aluOut;
        if (rst) begin
            laneResult.valid <= 1'b0;
        end else begin
            laneResult.valid <= issueValid;
        end
    end

endmodule

/* issueCore.sv */
`timescale 1ns/100ps

module issueCore #(
    parameter int NUM_LANES  = 2,
    parameter int QUEUE_SIZE = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         uopValid [NUM_LANES],
    input  uopPkg::rUop_t                uop [NUM_LANES],
    input  logic                         invalidate,
    input  sizingPkg::sqN_t              invalidateSqN,
    input  sizingPkg::sqN_t              nextCommitSqN,
    output uopPkg::resultBus_t           result [NUM_LANES],
    output logic [sizingPkg::FREE_W-1:0] free
);
    import uopPkg::*;

    logic       issueValid [NUM_LANES];
    laneIssue_t issue [NUM_LANES];
    resultBus_t laneResult [NUM_LANES];

    reservationStation #(
        .NUM_LANES  (NUM_LANES),
        .QUEUE_SIZE (QUEUE_SIZE)
    ) rs0 (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .uop           (uop),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .nextCommitSqN (nextCommitSqN),
        .resultBus     (result),
        .issueValid    (issueValid),
        .issue         (issue),
        .free          (free)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        intLane lane0 (
            .clk        (clk),
            .rst        (rst),
            .issueValid (issueValid[i]),
            .issue      (issue[i]),
            .laneResult (laneResult[i])
        );
    end

    writebackStage #(
        .NUM_LANES (NUM_LANES)
    ) wb0 (
        .clk           (clk),
        .rst           (rst),
        .laneResult    (laneResult),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .result        (result)
    );

endmodule

/* issueCore_props.sv */
`timescale 1ns/100ps

module issueCoreProps #(
    parameter int NUM_LANES = 2
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         uopValid [NUM_LANES],
    input logic                         invalidate,
    input sizingPkg::sqN_t              nextCommitSqN,
    input logic                         issueValid [NUM_LANES],
    input uopPkg::laneIssue_t           issue [NUM_LANES],
    input logic [sizingPkg::FREE_W-1:0] free
);
    import uopPkg::*;

    int   dispatchCount;
    logic anyIssue;
    logic sameSqN;
    int   failCount = 0;

    always_comb begin
        dispatchCount = 0;
        anyIssue = 1'b0;
        sameSqN = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            dispatchCount += int'(uopValid[i]);
            anyIssue |= issueValid[i];
            for (int k = i + 1; k < NUM_LANES; k++) begin
                if (issueValid[i] && issueValid[k] && issue[i].sqN == issue[k].sqN) begin
                    sameSqN = 1'b1;
                end
            end
        end
    end

    dispatchWithinFree: assert property (@(posedge clk) disable iff (rst)
        dispatchCount <= int'(free))
        else begin
            $error("more micro-ops dispatched than free entries");
            failCount++;
        end

    distinctIssueSqN: assert property (@(posedge clk) disable iff (rst) !sameSqN)
        else begin
            $error("two issue slots carry the same sequence number");
            failCount++;
        end

    quietAfterFlush: assert property (@(posedge clk) disable iff (rst)
        invalidate |=> !anyIssue)
        else begin
            $error("issue valid in the cycle after invalidate");
            failCount++;
        end

    for (genvar i = 0; i < NUM_LANES; i++) begin : gCsrr
        csrrAtCommit: assert property (@(posedge clk) disable iff (rst)
            issueValid[i] && issue[i].op == INT_CSRR |-> issue[i].sqN == $past(nextCommitSqN))
            else begin
                $error("csr read issued ahead of the commit pointer");
                failCount++;
            end
    end

endmodule

bind reservationStation issueCoreProps #(
    .NUM_LANES (NUM_LANES)
) props0 (
    .clk           (clk),
    .rst           (rst),
    .uopValid      (uopValid),
    .invalidate    (invalidate),
    .nextCommitSqN (nextCommitSqN),
    .issueValid    (issueValid),
    .issue         (issue),
    .free          (free)
);

/* reservationStation.sv */
`timescale 1ns/100ps

module reservationStation #(
    parameter int NUM_LANES  = 2,
    parameter int QUEUE_SIZE = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         uopValid [NUM_LANES],
    input  uopPkg::rUop_t                uop [NUM_LANES],
    input  logic                         invalidate,
    input  sizingPkg::sqN_t              invalidateSqN,
    input  sizingPkg::sqN_t              nextCommitSqN,
    input  uopPkg::resultBus_t           resultBus [NUM_LANES],
    output logic                         issueValid [NUM_LANES],
    output uopPkg::laneIssue_t           issue [NUM_LANES],
    output logic [sizingPkg::FREE_W-1:0] free
);
    import sizingPkg::*;
    import uopPkg::*;

    localparam int IDX_W = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    rUop_t                 entry [QUEUE_SIZE];
    logic [QUEUE_SIZE-1:0] valid;
    logic [QUEUE_SIZE-1:0] ordered;
    logic [QUEUE_SIZE-1:0] ready;
    logic [QUEUE_SIZE-1:0] validNext;
    logic [QUEUE_SIZE-1:0] claimed;
    logic [QUEUE_SIZE-1:0] taken;

    logic                  enqValid [NUM_LANES];
    logic [IDX_W-1:0]      enqIdx [NUM_LANES];
    rUop_t                 enqUop [NUM_LANES];

    logic                  selValid [NUM_LANES];
    logic [IDX_W-1:0]      selIdx [NUM_LANES];

    logic [FREE_W-1:0]     freeNext;

    // capture a pending operand from any matching bus slot.
    function automatic operand_t wake(operand_t src);
        operand_t res;
        res = src;
        for (int b = 0; b < NUM_LANES; b++) begin
            if (resultBus[b].valid && !res.avail && resultBus[b].tag == src.tag) begin
                res.avail = 1'b1;
                res.value = resultBus[b].value;
            end
        end
        return res;
    endfunction

    // free slots are handed out in dispatch slot order.
    always_comb begin
        logic found;
        claimed = valid;
        for (int k = 0; k < NUM_LANES; k++) begin
            found = 1'b0;
            enqIdx[k] = '0;
            for (int j = 0; j < QUEUE_SIZE; j++) begin
                if (!found && !claimed[j]) begin
                    found = 1'b1;
                    enqIdx[k] = IDX_W'(j);
                end
            end
            if (found && uopValid[k]) begin
                claimed[enqIdx[k]] = 1'b1;
            end
            enqValid[k] = uopValid[k] && found && !invalidate;
            enqUop[k] = uop[k];
            enqUop[k].srcA = wake(uop[k].srcA);
            enqUop[k].srcB = wake(uop[k].srcB);
        end
    end

    always_comb begin
        for (int j = 0; j < QUEUE_SIZE; j++) begin
            ready[j] = valid[j] && entry[j].srcA.avail && entry[j].srcB.avail &&
                       (!ordered[j] || entry[j].sqN == nextCommitSqN);
        end
    end

    // oldest ready entry per lane, ordered ops to lane 0 only.
    always_comb begin
        taken = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            selValid[i] = 1'b0;
            selIdx[i] = '0;
            for (int j = 0; j < QUEUE_SIZE; j++) begin
                if (ready[j] && !taken[j] && (!ordered[j] || i == 0) &&
                    (!selValid[i] || isOlder(entry[j].sqN, entry[selIdx[i]].sqN))) begin
                    selValid[i] = 1'b1;
                    selIdx[i] = IDX_W'(j);
                end
            end
            if (selValid[i]) begin
                taken[selIdx[i]] = 1'b1;
            end
        end
    end

    always_comb begin
        validNext = valid;
        if (invalidate) begin
            for (int j = 0; j < QUEUE_SIZE; j++) begin
                if (valid[j] && isOlder(invalidateSqN, entry[j].sqN)) begin
                    validNext[j] = 1'b0;
                end
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (selValid[i]) begin
                    validNext[selIdx[i]] = 1'b0;
                end
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                if (enqValid[k]) begin
                    validNext[enqIdx[k]] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        freeNext = FREE_W'(QUEUE_SIZE);
        for (int j = 0; j < QUEUE_SIZE; j++) begin
            if (validNext[j]) begin
                freeNext = freeNext - 1'b1;
            end
        end
    end

    // entry payload and issue register.
    always_ff @(posedge clk) begin
        for (int j = 0; j < QUEUE_SIZE; j++) begin
            entry[j].srcA <= wake(entry[j].srcA);
            entry[j].srcB <= wake(entry[j].srcB);
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            if (enqValid[k]) begin
                entry[enqIdx[k]] <= enqUop[k];
                ordered[enqIdx[k]] <= (enqUop[k].op == INT_CSRR);
            end
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            issue[i].op     <= entry[selIdx[i]].op;
            issue[i].sqN    <= entry[selIdx[i]].sqN;
            issue[i].tagDst <= entry[selIdx[i]].tagDst;
            issue[i].valueA <= entry[selIdx[i]].srcA.value;
            issue[i].valueB <= entry[selIdx[i]].srcB.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            free <= FREE_W'(QUEUE_SIZE);
            for (int i = 0; i < NUM_LANES; i++) begin
                issueValid[i] <= 1'b0;
            end
        end else begin
            valid <= validNext;
            free <= freeNext;
            for (int i = 0; i < NUM_LANES; i++) begin
                issueValid[i] <= selValid[i] && !invalidate;
            end
        end
    end

endmodule

/* sizingPkg.sv */
package sizingPkg;

    localparam int TAG_W  = 6;
    localparam int SQN_W  = 6;
    localparam int DATA_W = 32;
    localparam int FREE_W = 5;

    typedef logic [SQN_W-1:0]  sqN_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [DATA_W-1:0] data_t;

    // true when a is older than b, by wrap-around difference.
    function automatic logic isOlder(sqN_t a, sqN_t b);
        sqN_t diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

endpackage

/* tbIssueCore.sv */
`timescale 1ns/100ps

module tbIssueCore;
    import sizingPkg::*;
    import uopPkg::*;

    localparam int NUM_LANES  = 2;
    localparam int QUEUE_SIZE = 8;
    localparam int NUM_TAGS   = 1 << TAG_W;

    // two dispatch slots plus control per row.
    // a lat of zero skips the latency check.
    typedef struct packed {
        logic       v0;
        rUop_t      u0;
        logic [3:0] lat0;
        logic       v1;
        rUop_t      u1;
        logic [3:0] lat1;
        logic       inv;
        sqN_t       invSqN;
        sqN_t       commit;
        logic [7:0] idle;
        logic       chkFree;
    } stimRow_t;

    logic              clk;
    logic              rst;
    logic              uopValid [NUM_LANES];
    rUop_t             uop [NUM_LANES];
    logic              invalidate;
    sqN_t              invalidateSqN;
    sqN_t              nextCommitSqN;
    resultBus_t        result [NUM_LANES];
    logic [FREE_W-1:0] free;

    stimRow_t stim [$];
    stimRow_t curRow;
    integer   seed = 70984;
    sqN_t     nextSqN = sqN_t'(1);
    tag_t     nextTag = tag_t'(1);
    sqN_t     lastSqN;
    tag_t     lastTag;
    sqN_t     rowCommit = '0;
    int       cyc = 0;
    // reset and final drain.
    int       totalCycles = 18;
    bit       tableReady = 1'b0;

    data_t expVal [NUM_TAGS];
    sqN_t  expSqN [NUM_TAGS];
    int    expCyc [NUM_TAGS];
    bit    dispatched [NUM_TAGS];
    bit    killed [NUM_TAGS];
    bit    seen [NUM_TAGS];

    issueCore #(
        .NUM_LANES  (NUM_LANES),
        .QUEUE_SIZE (QUEUE_SIZE)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .uop           (uop),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .nextCommitSqN (nextCommitSqN),
        .result        (result),
        .free          (free)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic operand_t freshOperand();
        operand_t o;
        o.avail = 1'b1;
        o.tag = '0;
        o.value = $random(seed);
        return o;
    endfunction

    function automatic operand_t pendingOn(tag_t t);
        operand_t o;
        o.avail = 1'b0;
        o.tag = t;
        o.value = '0;
        return o;
    endfunction

    function automatic data_t aluRef(intOp_e op, data_t a, data_t b);
        case (op)
            INT_ADD:  return a + b;
            INT_SUB:  return a - b;
            INT_AND:  return a & b;
            INT_OR:   return a | b;
            INT_XOR:  return a ^ b;
            INT_SLT:  return data_t'($signed(a) < $signed(b));
            INT_SLTU: return data_t'(a < b);
            default:  return a;
        endcase
    endfunction

    task automatic addOp(input int slot, input intOp_e op, input operand_t a,
                         input operand_t b, input int lat);
        rUop_t u;
        u.op = op;
        u.sqN = nextSqN;
        u.tagDst = nextTag;
        u.srcA = a;
        u.srcB = b;
        lastSqN = nextSqN;
        lastTag = nextTag;
        nextSqN = nextSqN + sqN_t'(1);
        nextTag = nextTag + tag_t'(1);
        if (slot == 0) begin
            curRow.v0 = 1'b1;
            curRow.u0 = u;
            curRow.lat0 = 4'(lat);
        end else begin
            curRow.v1 = 1'b1;
            curRow.u1 = u;
            curRow.lat1 = 4'(lat);
        end
    endtask

    task automatic endRow(input int idle, input bit chkFree);
        curRow.idle = 8'(idle);
        curRow.chkFree = chkFree;
        curRow.commit = rowCommit;
        stim.push_back(curRow);
        totalCycles += 1 + idle;
        curRow = '0;
    endtask

    task automatic buildTable();
        tag_t tp;
        tag_t tq;
        sqN_t keepSqN;
        curRow = '0;
        for (int k = 0; k < 7; k++) begin
            addOp(0, intOp_e'(k), freshOperand(), freshOperand(), 3);
            addOp(1, intOp_e'(k), freshOperand(), freshOperand(), 3);
            endRow((k == 6) ? 5 : 0, k == 6);
        end
        // the xor of this chain catches its source off the bus at dispatch.
        addOp(0, INT_ADD, freshOperand(), freshOperand(), 3);
        tp = lastTag;
        addOp(1, INT_SUB, pendingOn(tp), freshOperand(), 7);
        tq = lastTag;
        endRow(3, 0);
        addOp(0, INT_XOR, pendingOn(tp), freshOperand(), 3);
        addOp(1, INT_OR, pendingOn(tq), pendingOn(lastTag), 0);
        endRow(10, 1);
        // four waiters wake at once on two lanes.
        addOp(0, INT_ADD, freshOperand(), freshOperand(), 3);
        tp = lastTag;
        addOp(1, INT_AND, pendingOn(tp), freshOperand(), 7);
        endRow(0, 0);
        addOp(0, INT_SLT, freshOperand(), pendingOn(tp), 6);
        addOp(1, INT_SLTU, pendingOn(tp), freshOperand(), 7);
        endRow(0, 0);
        addOp(0, INT_SUB, pendingOn(tp), pendingOn(tp), 6);
        endRow(8, 1);
        // csr read waits for commit while a younger add passes it.
        addOp(0, INT_CSRR, freshOperand(), freshOperand(), 7);
        keepSqN = lastSqN;
        addOp(1, INT_ADD, freshOperand(), freshOperand(), 3);
        endRow(4, 0);
        rowCommit = keepSqN;
        endRow(6, 1);
        // flush hits a waiting entry, a lane result and the issue register.
        addOp(0, INT_ADD, freshOperand(), freshOperand(), 3);
        tp = lastTag;
        addOp(1, INT_XOR, pendingOn(tp), freshOperand(), 7);
        keepSqN = lastSqN;
        endRow(0, 0);
        addOp(0, INT_OR, freshOperand(), freshOperand(), 0);
        addOp(1, INT_ADD, pendingOn(lastTag), freshOperand(), 0);
        endRow(0, 0);
        addOp(0, INT_AND, freshOperand(), freshOperand(), 0);
        endRow(1, 0);
        curRow.inv = 1'b1;
        curRow.invSqN = keepSqN;
        endRow(8, 1);
        addOp(0, INT_XOR, freshOperand(), freshOperand(), 3);
        addOp(1, INT_SUB, freshOperand(), freshOperand(), 3);
        endRow(6, 1);
    endtask

    task automatic recordOp(input rUop_t u, input int lat);
        data_t a;
        data_t b;
        a = u.srcA.avail ? u.srcA.value : expVal[u.srcA.tag];
        b = u.srcB.avail ? u.srcB.value : expVal[u.srcB.tag];
        expVal[u.tagDst] = aluRef(u.op, a, b);
        expSqN[u.tagDst] = u.sqN;
        expCyc[u.tagDst] = (lat == 0) ? -1 : cyc + 1 + lat;
        dispatched[u.tagDst] = 1'b1;
    endtask

    // sequence numbers stay below the wrap point in this table.
    task automatic markFlushed(input sqN_t invSqN);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (dispatched[t] && expSqN[t] > invSqN) begin
                killed[t] = 1'b1;
            end
        end
    endtask

    task automatic applyRow(input stimRow_t r);
        uopValid[0] = r.v0;
        uop[0] = r.u0;
        uopValid[1] = r.v1;
        uop[1] = r.u1;
        invalidate = r.inv;
        invalidateSqN = r.invSqN;
        nextCommitSqN = r.commit;
        if (r.v0) begin
            recordOp(r.u0, r.lat0);
        end
        if (r.v1) begin
            recordOp(r.u1, r.lat1);
        end
        if (r.inv) begin
            markFlushed(r.invSqN);
        end
    endtask

    task automatic abortRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        abortRun();
    endtask

    task automatic compareResult(input resultBus_t got, input resultBus_t exp);
        if (got !== exp) begin
            $display("** Error @ %0t: tag %0d got sqN %0d value %h, expected sqN %0d value %h",
                     $time, exp.tag, got.sqN, got.value, exp.sqN, exp.value);
            abortRun();
        end
    endtask

    task automatic compareFree(input logic [FREE_W-1:0] got, input logic [FREE_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: free is %0d, expected %0d", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBusSlot(input resultBus_t got);
        tag_t       t;
        resultBus_t exp;
        t = got.tag;
        if (!dispatched[t]) begin
            reportFailure($sformatf("result for tag %0d, which was never dispatched", t));
        end else if (killed[t]) begin
            reportFailure($sformatf("flushed op with tag %0d reached the result bus", t));
        end else if (seen[t]) begin
            reportFailure($sformatf("result for tag %0d appeared twice", t));
        end else begin
            exp = '{valid: 1'b1, sqN: expSqN[t], tag: t, value: expVal[t]};
            compareResult(got, exp);
            if (expCyc[t] >= 0 && expCyc[t] != cyc) begin
                reportFailure($sformatf("result for tag %0d arrived in cycle %0d, not %0d",
                                        t, cyc, expCyc[t]));
            end
            seen[t] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (result[i].valid) begin
                    checkBusSlot(result[i]);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (dut0.rs0.props0.failCount != 0) begin
            reportFailure("an assertion bound to the reservation station failed");
        end
    end

    initial begin
        wait (tableReady);
        #((totalCycles + 50) * 8);
        $display("watchdog expired before the table finished");
        abortRun();
    end

    initial begin
        int missing;
        rst = 1'b1;
        invalidate = 1'b0;
        invalidateSqN = '0;
        nextCommitSqN = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            uopValid[i] = 1'b0;
            uop[i] = '0;
        end
        buildTable();
        tableReady = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (stim[n]) begin
            applyRow(stim[n]);
            @(posedge clk);
            #1;
            uopValid[0] = 1'b0;
            uopValid[1] = 1'b0;
            invalidate = 1'b0;
            repeat (stim[n].idle) begin
                @(posedge clk);
                #1;
            end
            if (stim[n].chkFree) begin
                compareFree(free, FREE_W'(QUEUE_SIZE));
            end
        end
        repeat (10) @(posedge clk);
        #1;
        missing = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (dispatched[t] && !killed[t] && !seen[t]) begin
                $display("tag %0d never appeared on the result bus", t);
                missing++;
            end
        end
        if (dut0.rs0.props0.failCount != 0) begin
            $display("an assertion bound to the reservation station failed");
        end
        if (missing == 0 && dut0.rs0.props0.failCount == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

/* uopPkg.sv */
package uopPkg;

    import sizingPkg::*;

    // INT_CSRR is ordered and returns operand A.
    typedef enum logic [2:0] {
        INT_ADD,
        INT_SUB,
        INT_AND,
        INT_OR,
        INT_XOR,
        INT_SLT,
        INT_SLTU,
        INT_CSRR
    } intOp_e;

    // source operand, either a value or a tag still pending.
    typedef struct packed {
        logic  avail;
        tag_t  tag;
        data_t value;
    } operand_t;

    // renamed micro-op from dispatch.
    typedef struct packed {
        intOp_e   op;
        sqN_t     sqN;
        tag_t     tagDst;
        operand_t srcA;
        operand_t srcB;
    } rUop_t;

    // operation handed to one lane.
    typedef struct packed {
        intOp_e op;
        sqN_t   sqN;
        tag_t   tagDst;
        data_t  valueA;
        data_t  valueB;
    } laneIssue_t;

    // one slot of the result bus.
    typedef struct packed {
        logic  valid;
        sqN_t  sqN;
        tag_t  tag;
        data_t value;
    } resultBus_t;

endpackage

/* writebackStage.sv */
`timescale 1ns/100ps

module writebackStage #(
    parameter int NUM_LANES = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  uopPkg::resultBus_t laneResult [NUM_LANES],
    input  logic               invalidate,
    input  sizingPkg::sqN_t    invalidateSqN,
    output uopPkg::resultBus_t result [NUM_LANES]
);
    import sizingPkg::*;

    logic killPending;
    sqN_t killSqN;
    logic stale [NUM_LANES];

    // the op in the issue register at the invalidate edge
    // reaches the lanes one edge later, so the kill is held one cycle.
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            stale[i] = (invalidate && isOlder(invalidateSqN, laneResult[i].sqN)) ||
                       (killPending && isOlder(killSqN, laneResult[i].sqN));
        end
    end

    always_ff @(posedge clk) begin
        killSqN <= invalidateSqN;
        for (int i = 0; i < NUM_LANES; i++) begin
            result[i].sqN   <= laneResult[i].sqN;
            result[i].tag   <= laneResult[i].tag;
            result[i].value <= laneResult[i].value;
        end
        if (rst) begin
            killPending <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                result[i].valid <= 1'b0;
            end
        end else begin
            killPending <= invalidate;
            for (int i = 0; i < NUM_LANES; i++) begin
                result[i].valid <= laneResult[i].valid && !stale[i];
            end
        end
    end

endmodule
